// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_rr_arbiter
FILELIST  := rr_arbiter.f
BUILD_DIR := obj_dir
PASS_MSG  := All checks passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/tb_vectors.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# output goes to the terminal, status follows the pass search
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: arbiter/grant_control.sv
/*
 * Round-robin grant controller.
 * Masks requests at or below the last winner, picks the masked
 * encoder result when it has one and the plain result otherwise,
 * and holds the registered grant while its request stays high.
 */

`timescale 1ns/10ps
`default_nettype none

module grant_control
    import arb_pkg::*;
#(
    parameter int PORTS = ARB_PORTS
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire [PORTS-1:0]           request,
    output logic [PORTS-1:0]          req_masked,

    // encoder fed with req_masked
    input  wire                       masked_valid,
    input  wire [$clog2(PORTS)-1:0]   masked_encoded,
    input  wire [PORTS-1:0]           masked_unencoded,

    // encoder fed with the raw requests
    input  wire                       plain_valid,
    input  wire [$clog2(PORTS)-1:0]   plain_encoded,
    input  wire [PORTS-1:0]           plain_unencoded,

    output logic [PORTS-1:0]          grant,
    output logic                      grant_valid,
    output logic [$clog2(PORTS)-1:0]  grant_encoded
);

    localparam int IDX_W = $clog2(PORTS);

    arb_state_t         state;
    logic [IDX_W-1:0]   last_idx;
    logic               first_round;
    logic [PORTS-1:0]   pass_mask;

    logic               held;
    logic               decide;
    logic               sel_valid;
    logic [IDX_W-1:0]   sel_encoded;
    logic [PORTS-1:0]   sel_unencoded;

    // only indices above the last winner pass
    // everything passes until the first grant after reset
    always_comb begin
        for (int i = 0; i < PORTS; i++) begin
            pass_mask[i] = first_round || (IDX_W'(i) > last_idx);
        end
    end

    assign req_masked = request & pass_mask;

    // granted requester still asserting
    assign held = |(request & grant);

    // new decision from idle or once the held request drops
    assign decide = (state == ARB_IDLE) || !held;

    // masked path first, wrap to the plain path when it is empty
    always_comb begin
        if (masked_valid) begin
            sel_valid     = 1'b1;
            sel_encoded   = masked_encoded;
            sel_unencoded = masked_unencoded;
        end else begin
            sel_valid     = plain_valid;
            sel_encoded   = plain_encoded;
            sel_unencoded = plain_unencoded;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ARB_IDLE;
            grant         <= '0;
            grant_encoded <= '0;
            last_idx      <= '0;
            first_round   <= 1'b1;
        end else if (decide) begin
            if (sel_valid) begin
                state         <= ARB_HOLD;
                grant         <= sel_unencoded;
                grant_encoded <= sel_encoded;
                // next round starts above this winner
                last_idx      <= sel_encoded;
                first_round   <= 1'b0;
            end else begin
                // no requests, drop the grant but keep the last winner
                state         <= ARB_IDLE;
                grant         <= '0;
                grant_encoded <= '0;
            end
        end
    end

    assign grant_valid = (state == ARB_HOLD);

endmodule

`default_nettype wire

// File: arbiter/rr_arbiter.sv
/*
 * Round-robin request arbiter top level.
 * Two priority encoders run side by side on the masked and
 * the raw requests, the grant controller picks and holds.
 */

`timescale 1ns/10ps
`default_nettype none

module rr_arbiter
    import arb_pkg::*;
(
    input  wire          clk,
    input  wire          rst,

    input  wire req_vec_t request,

    output req_vec_t     grant,
    output logic         grant_valid,
    output port_idx_t    grant_encoded
);

    // requests above the last winner
    req_vec_t    req_masked;

    // masked encoder results
    logic        masked_valid;
    port_idx_t   masked_encoded;
    req_vec_t    masked_unencoded;

    // plain encoder results
    logic        plain_valid;
    port_idx_t   plain_encoded;
    req_vec_t    plain_unencoded;

    // lowest requester above the last winner
    priority_encoder #(
        .WIDTH (ARB_PORTS)
    ) enc_masked (
        .input_unencoded  (req_masked),
        .output_valid     (masked_valid),
        .output_encoded   (masked_encoded),
        .output_unencoded (masked_unencoded)
    );

    // lowest requester overall, used on wrap
    priority_encoder #(
        .WIDTH (ARB_PORTS)
    ) enc_plain (
        .input_unencoded  (request),
        .output_valid     (plain_valid),
        .output_encoded   (plain_encoded),
        .output_unencoded (plain_unencoded)
    );

    grant_control #(
        .PORTS (ARB_PORTS)
    ) u_grant_control (
        .clk              (clk),
        .rst              (rst),
        .request          (request),
        .req_masked       (req_masked),
        .masked_valid     (masked_valid),
        .masked_encoded   (masked_encoded),
        .masked_unencoded (masked_unencoded),
        .plain_valid      (plain_valid),
        .plain_encoded    (plain_encoded),
        .plain_unencoded  (plain_unencoded),
        .grant            (grant),
        .grant_valid      (grant_valid),
        .grant_encoded    (grant_encoded)
    );

endmodule

`default_nettype wire

// File: bench/tb_vectors.svh
/*
 * Directed stimulus table for the round-robin arbiter testbench.
 * Each row holds a request value and the grant, grant_valid and
 * grant_encoded expected one edge after that request is sampled.
 */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// columns are request, expected grant, expected grant_valid, expected grant_encoded
typedef struct packed {
    req_vec_t  req;
    req_vec_t  grant;
    logic      valid;
    port_idx_t idx;
} vector_t;

localparam int NUM_VECTORS = 32;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors;
    // first decision after reset starts at index 0
    vectors[0]  = {5'b00000, 5'b00000, 1'b0, 3'd0};
    vectors[1]  = {5'b00011, 5'b00001, 1'b1, 3'd0};
    vectors[2]  = {5'b00000, 5'b00000, 1'b0, 3'd0};
    // single requests from idle with index 4 in the padded half
    vectors[3]  = {5'b10000, 5'b10000, 1'b1, 3'd4};
    vectors[4]  = {5'b10000, 5'b10000, 1'b1, 3'd4};
    vectors[5]  = {5'b00000, 5'b00000, 1'b0, 3'd0};
    vectors[6]  = {5'b00100, 5'b00100, 1'b1, 3'd2};
    vectors[7]  = {5'b00000, 5'b00000, 1'b0, 3'd0};
    vectors[8]  = {5'b00001, 5'b00001, 1'b1, 3'd0};
    // hand-over with no idle gap
    vectors[9]  = {5'b00010, 5'b00010, 1'b1, 3'd1};
    vectors[10] = {5'b01000, 5'b01000, 1'b1, 3'd3};
    vectors[11] = {5'b10000, 5'b10000, 1'b1, 3'd4};
    vectors[12] = {5'b00000, 5'b00000, 1'b0, 3'd0};
    // all high after winner 4 so the round wraps to 0
    vectors[13] = {5'b11111, 5'b00001, 1'b1, 3'd0};
    vectors[14] = {5'b11111, 5'b00001, 1'b1, 3'd0};
    vectors[15] = {5'b11111, 5'b00001, 1'b1, 3'd0};
    // winners drop one by one for the rotation 1 2 3 4 0
    vectors[16] = {5'b11110, 5'b00010, 1'b1, 3'd1};
    vectors[17] = {5'b11111, 5'b00010, 1'b1, 3'd1};
    vectors[18] = {5'b11101, 5'b00100, 1'b1, 3'd2};
    vectors[19] = {5'b11011, 5'b01000, 1'b1, 3'd3};
    vectors[20] = {5'b10111, 5'b10000, 1'b1, 3'd4};
    vectors[21] = {5'b01111, 5'b00001, 1'b1, 3'd0};
    // upper requester beats lower ones and then wraps
    vectors[22] = {5'b01100, 5'b00100, 1'b1, 3'd2};
    vectors[23] = {5'b01011, 5'b01000, 1'b1, 3'd3};
    vectors[24] = {5'b00011, 5'b00001, 1'b1, 3'd0};
    // no pre-emption by lower indices
    vectors[25] = {5'b10000, 5'b10000, 1'b1, 3'd4};
    vectors[26] = {5'b10111, 5'b10000, 1'b1, 3'd4};
    vectors[27] = {5'b00100, 5'b00100, 1'b1, 3'd2};
    // all drop and the next round resumes above 2
    vectors[28] = {5'b00000, 5'b00000, 1'b0, 3'd0};
    vectors[29] = {5'b00000, 5'b00000, 1'b0, 3'd0};
    vectors[30] = {5'b01011, 5'b01000, 1'b1, 3'd3};
    vectors[31] = {5'b00000, 5'b00000, 1'b0, 3'd0};
endtask

`endif

// File: bench/tb_rr_arbiter.sv
/*
 * Round-robin arbiter testbench.
 * Applies a directed table, then LFSR driven requests checked
 * against a cycle-level reference model of the grant rules.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_rr_arbiter
    import arb_pkg::*;
();

    localparam int WAIT_LIMIT    = 10;
    localparam int RANDOM_CYCLES = 200;

    logic       clk;
    logic       rst;
    req_vec_t   request;
    req_vec_t   grant;
    logic       grant_valid;
    port_idx_t  grant_encoded;

    // request value the DUT saw at the last edge
    req_vec_t   sampled;

    // reference model state
    logic       m_valid;
    req_vec_t   m_grant;
    port_idx_t  m_idx;
    int         m_last;
    logic       m_first;

    logic [31:0] lfsr;

    `include "tb_vectors.svh"

    rr_arbiter UUT (
        .clk           (clk),
        .rst           (rst),
        .request       (request),
        .grant         (grant),
        .grant_valid   (grant_valid),
        .grant_encoded (grant_encoded)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_failure;
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_grant(input string name, input req_vec_t expected,
                               input req_vec_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_index(input string name, input port_idx_t expected,
                               input port_idx_t actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    // one-hot or zero, and only on a high request bit
    task automatic verify_grant_shape;
        if (!$onehot0(grant)) begin
            $display("grant has more than one bit set");
            stop_on_failure();
        end
        if (|(grant & ~sampled)) begin
            $display("grant points to a requester whose request is low");
            stop_on_failure();
        end
    endtask

    // Galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            lfsr_next = (state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_next = state >> 1;
        end
    endfunction

    // one lfsr step per request bit
    task automatic draw_request(output req_vec_t value);
        for (int b = 0; b < ARB_PORTS; b++) begin
            lfsr = lfsr_next(lfsr);
            value[b] = lfsr[0];
        end
    endtask

    // one decision edge of the reference model
    task automatic model_step(input req_vec_t req);
        int win;
        win = -1;
        if (!m_valid || !req[m_idx]) begin
            // above the last winner first
            for (int i = 0; i < ARB_PORTS; i++) begin
                if (win < 0 && req[i] && (m_first || i > m_last)) begin
                    win = i;
                end
            end
            // wrap to the lowest index
            for (int i = 0; i < ARB_PORTS; i++) begin
                if (win < 0 && req[i]) begin
                    win = i;
                end
            end
            if (win >= 0) begin
                m_valid = 1'b1;
                m_idx   = port_idx_t'(win);
                m_grant = req_vec_t'(1) << win;
                m_last  = win;
                m_first = 1'b0;
            end else begin
                // last winner kept across idle
                m_valid = 1'b0;
                m_idx   = '0;
                m_grant = '0;
            end
        end
    endtask

    // drive at the edge, model that edge, check at the falling edge
    task automatic apply_cycle(input req_vec_t next_req);
        @(posedge clk);
        sampled = request;
        model_step(request);
        request <= next_req;
        @(negedge clk);
        check_grant("grant", m_grant, grant);
        check_valid("grant_valid", m_valid, grant_valid);
        check_index("grant_encoded", m_idx, grant_encoded);
        verify_grant_shape();
    endtask

    // request held, bounded wait for grant_valid
    task automatic wait_for_valid(input logic level);
        int count;
        count = 0;
        while (grant_valid !== level) begin
            if (count == WAIT_LIMIT) begin
                $display("grant_valid did not reach %0b within %0d cycles", level, WAIT_LIMIT);
                stop_on_failure();
            end
            apply_cycle(request);
            count++;
        end
    endtask

    initial begin
        req_vec_t next_req;
        rst     = 1'b1;
        request = '0;
        sampled = '0;
        lfsr    = 32'h0ee1_f4aa;
        m_valid = 1'b0;
        m_grant = '0;
        m_idx   = '0;
        m_last  = 0;
        m_first = 1'b1;
        load_vectors();

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_grant("grant", '0, grant);
        check_valid("grant_valid", 1'b0, grant_valid);
        check_index("grant_encoded", '0, grant_encoded);

        // row i-1 shows up while row i is being driven
        for (int i = 0; i <= NUM_VECTORS; i++) begin
            if (i < NUM_VECTORS) begin
                apply_cycle(vectors[i].req);
            end else begin
                apply_cycle('0);
            end
            if (i > 0) begin
                check_grant("grant", vectors[i-1].grant, grant);
                check_valid("grant_valid", vectors[i-1].valid, grant_valid);
                check_index("grant_encoded", vectors[i-1].idx, grant_encoded);
            end
        end

        apply_cycle('1);
        wait_for_valid(1'b1);
        apply_cycle('0);
        wait_for_valid(1'b0);

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            draw_request(next_req);
            apply_cycle(next_req);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: common/arb_pkg.sv
/*
 * Round-robin arbiter shared definitions.
 * Requester count, index width, vector types and the
 * grant controller state encoding.
 */

`default_nettype none

package arb_pkg;

    // number of requesters, 5 so the encoder pads to 8
    localparam int ARB_PORTS = 5;

    // width of an encoded requester index
    localparam int ARB_IDX_W = $clog2(ARB_PORTS);

    // one bit per requester, used for requests and one-hot grants
    typedef logic [ARB_PORTS-1:0] req_vec_t;

    // encoded requester index
    typedef logic [ARB_IDX_W-1:0] port_idx_t;

    // grant controller states
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_HOLD = 1'b1
    } arb_state_t;

endpackage

`default_nettype wire

// File: rr_arbiter.f
+incdir+bench
common/arb_pkg.sv
src/priority_encoder.sv
arbiter/grant_control.sv
arbiter/rr_arbiter.sv
bench/tb_rr_arbiter.sv

// File: src/priority_encoder.sv
/*
 * Recursive priority encoder.
 * Purely combinational. The lowest set input bit wins and is
 * returned both as an index and as a one-hot vector. Widths
 * that are not a power of two are padded with zeros on top.
 */

`timescale 1ns/10ps
`default_nettype none

module priority_encoder #(
    parameter int WIDTH = 4
) (
    input  wire [WIDTH-1:0]         input_unencoded,
    output logic                    output_valid,
    output logic [$clog2(WIDTH)-1:0] output_encoded,
    output logic [WIDTH-1:0]        output_unencoded
);

    localparam int IDX_W = $clog2(WIDTH);

    // padded power-of-two width and its half
    localparam int W1 = 2 ** IDX_W;
    localparam int W2 = W1 / 2;

    generate
        if (WIDTH == 2) begin : g_leaf
            // two inputs, OR gate for valid
            assign output_valid = |input_unencoded;
            // index 1 only when bit 0 is clear, zero when nothing set
            assign output_encoded = input_unencoded[1] & ~input_unencoded[0];
        end else begin : g_split
            logic [W1-1:0]            in_pad;
            logic                     valid_lo;
            logic                     valid_hi;
            logic [$clog2(W2)-1:0]    enc_lo;
            logic [$clog2(W2)-1:0]    enc_hi;

            // zero-extend to the power-of-two width
            always_comb begin
                in_pad = '0;
                in_pad[WIDTH-1:0] = input_unencoded;
            end

            // lower half
            priority_encoder #(
                .WIDTH (W2)
            ) enc_lo_inst (
                .input_unencoded  (in_pad[W2-1:0]),
                .output_valid     (valid_lo),
                .output_encoded   (enc_lo),
                .output_unencoded ()
            );

            // upper half, carries the padding
            priority_encoder #(
                .WIDTH (W2)
            ) enc_hi_inst (
                .input_unencoded  (in_pad[W1-1:W2]),
                .output_valid     (valid_hi),
                .output_encoded   (enc_hi),
                .output_unencoded ()
            );

            assign output_valid = valid_lo | valid_hi;

            // lower half wins whenever it has a request
            // msb is valid_hi so the index stays zero with no input
            assign output_encoded = valid_lo ? {1'b0, enc_lo} : {valid_hi, enc_hi};
        end
    endgenerate

    // one-hot decode of the index, all zero when nothing is set
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            output_unencoded[i] = output_valid && (output_encoded == IDX_W'(i));
        end
    end

endmodule

`default_nettype wire
